/* design/sparcIsaPkg.sv */
package sparcIsaPkg;

	// Format 2 view used by SETHI and Bicc
	typedef struct packed {
		logic [1:0] op;
		logic [4:0] rd;      // Annul bit and cond share these bits on branches
		logic [2:0] op2;
		logic [21:0] imm22;  // SETHI immediate or branch disp22
	} fmt2_t;

	// Format 3 view for ALU, state register, Ticc and memory ops
	typedef struct packed {
		logic [1:0] op;
		logic [4:0] rd;
		logic [5:0] op3;
		logic [4:0] rs1;
		logic i;             // Immediate operand select
		logic [12:0] simm13; // rs2 in the low five bits when i is clear
	} fmt3_t;

	typedef union packed {
		fmt2_t f2;
		fmt3_t f3;
	} instr_u;

	typedef enum logic [3:0] {
		icSethi,
		icBranch,
		icArith,
		icLoad,
		icStore,
		icReadState,
		icWriteState,
		icTicc,
		icIllegal
	} instrClass_t;

	typedef enum logic [1:0] {
		srPsr = 2'b01, // Same as op3[1:0] of the RD and WR opcodes
		srWim = 2'b10,
		srTbr = 2'b11
	} stateReg_t;

	typedef struct packed {
		instrClass_t iClass;
		stateReg_t stateReg;
		logic privileged; // State access from user mode
		logic setsCc;     // Arithmetic op with the cc bit
		logic useImm;     // i bit
	} decodedInstr_t;

	typedef logic [7:0] trapType_t;
	localparam trapType_t ttHardware = 8'h11;
	localparam trapType_t ttIllegal = 8'h02;
	localparam trapType_t ttPrivileged = 8'h03;
	localparam trapType_t ttTiccBase = 8'h80; // Software trap number added on top

	// Primary opcodes
	localparam logic [1:0] opFmt2 = 2'b00;
	localparam logic [1:0] opArith = 2'b10;
	localparam logic [1:0] opMem = 2'b11;

	localparam logic [2:0] op2Bicc = 3'b010;
	localparam logic [2:0] op2Sethi = 3'b100;

	// ALU op3 codes without the cc bit
	localparam logic [5:0] op3Add = 6'b000000;
	localparam logic [5:0] op3And = 6'b000001;
	localparam logic [5:0] op3Or = 6'b000010;
	localparam logic [5:0] op3Xor = 6'b000011;
	localparam logic [5:0] op3Sub = 6'b000100;
	localparam logic [5:0] op3Andn = 6'b000101;
	localparam logic [5:0] op3Orn = 6'b000110;
	localparam logic [5:0] op3Xnor = 6'b000111;
	localparam logic [5:0] op3Addx = 6'b001000;
	localparam logic [5:0] op3Subx = 6'b001100;
	localparam logic [5:0] op3CcBit = 6'b010000; // Set on the cc forms
	localparam logic [5:0] op3Sll = 6'b100101;
	localparam logic [5:0] op3Srl = 6'b100110;
	localparam logic [5:0] op3Sra = 6'b100111;

	// Privileged state access and Ticc
	localparam logic [5:0] op3Rdpsr = 6'b101001;
	localparam logic [5:0] op3Rdwim = 6'b101010;
	localparam logic [5:0] op3Rdtbr = 6'b101011;
	localparam logic [5:0] op3Wrpsr = 6'b110001;
	localparam logic [5:0] op3Wrwim = 6'b110010;
	localparam logic [5:0] op3Wrtbr = 6'b110011;
	localparam logic [5:0] op3Ticc = 6'b111010;

	// Memory op3 codes
	localparam logic [5:0] op3Ld = 6'b000000;
	localparam logic [5:0] op3Ldub = 6'b000001;
	localparam logic [5:0] op3Lduh = 6'b000010;
	localparam logic [5:0] op3Ldsb = 6'b001001;
	localparam logic [5:0] op3Ldsh = 6'b001010;
	localparam logic [5:0] op3St = 6'b000100;
	localparam logic [5:0] op3Stb = 6'b000101;
	localparam logic [5:0] op3Sth = 6'b000110;

endpackage

/* design/controlPkg.sv */
package controlPkg;

	// ALU A operand source
	typedef enum logic [1:0] {
		aSelRegA = 2'b00,
		aSelPc = 2'b01,
		aSelNpc = 2'b10
	} aluASel_t;

	// ALU B operand source
	typedef enum logic [3:0] {
		bSelRegB = 4'b0000,
		bSelExt = 4'b0001,
		bSelMdr = 4'b0010,
		bSelPc = 4'b0011,
		bSelFour = 4'b0110, // Constant 4 for PC stepping
		bSelWim = 4'b1000,
		bSelTbr = 4'b1001,
		bSelPsr = 4'b1010
	} aluBSel_t;

	typedef enum logic [1:0] {
		pcSelNpc = 2'b00,
		pcSelAlu = 2'b01,
		pcSelTbr = 2'b10 // Trap vector
	} pcInSel_t;

	typedef enum logic [2:0] {
		extSimm13 = 3'b000, // Sign extended simm13
		extSethi = 3'b100,  // imm22 << 10
		extDisp22 = 3'b101  // Sign extended disp22 << 2
	} extSel_t;

	typedef logic [5:0] aluOp_t; // ALU instructions pass op3 straight through
	localparam aluOp_t aluAdd = 6'd0;
	localparam aluOp_t aluXor = 6'd3; // WR writes rs1 xor operand2

	typedef logic [5:0] memOp_t;
	localparam memOp_t memFetch = sparcIsaPkg::op3Ld; // Instruction fetch is a word load

	typedef struct packed {
		// Register load strobes
		logic pcLoad;
		logic npcLoad;
		logic irLoad;
		logic marLoad;
		logic mdrLoad;
		logic regWrite;
		logic psrLoad;
		logic wimLoad;
		logic tbrLoad;
		logic clearAll;      // PC, PSR, TBR cleared after reset
		logic psrTrapEntry;  // Datapath saves S, enters supervisor, clears ET
		logic memEnable;     // Held until MFC
		logic mdrFromMem;    // MDR input from memory instead of ALU
		aluASel_t aluASel;
		aluBSel_t aluBSel;
		pcInSel_t pcInSel;
		extSel_t extSel;
		aluOp_t aluOp;
		memOp_t memOp;
		logic [4:0] rdAddr;
		logic [4:0] rs1Addr;
		logic [4:0] rs2Addr;
		sparcIsaPkg::trapType_t trapType; // TBR.tt while psrTrapEntry is high
	} ctrlWord_t;

endpackage

/* design/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
	input sparcIsaPkg::instr_u ir,
	input logic psrS,
	output sparcIsaPkg::decodedInstr_t decoded
);
	import sparcIsaPkg::*;

	logic [5:0] op3Base; // op3 with the cc bit stripped

	assign op3Base = ir.f3.op3 & ~op3CcBit;

	always_comb
	begin
		decoded = '0;
		decoded.iClass = icIllegal; // Anything unmatched traps
		case (ir.f2.op)
			opFmt2:
			begin
				if (ir.f2.op2 == op2Sethi)
					decoded.iClass = icSethi;
				else if (ir.f2.op2 == op2Bicc)
					decoded.iClass = icBranch; // Annul bit ignored
			end
			opArith:
			begin
				if (ir.f3.op3 inside {op3Rdpsr, op3Rdwim, op3Rdtbr})
					decoded.iClass = icReadState;
				else if (ir.f3.op3 inside {op3Wrpsr, op3Wrwim, op3Wrtbr})
					decoded.iClass = icWriteState;
				else if (ir.f3.op3 == op3Ticc)
					decoded.iClass = icTicc;
				else if (ir.f3.op3 inside {op3Sll, op3Srl, op3Sra})
					decoded.iClass = icArith; // Shifts never touch cc
				else if (!ir.f3.op3[5] && op3Base inside {op3Add, op3And, op3Or, op3Xor,
					op3Sub, op3Andn, op3Orn, op3Xnor, op3Addx, op3Subx})
					decoded.iClass = icArith;
			end
			opMem:
			begin
				if (ir.f3.op3 inside {op3Ld, op3Ldub, op3Lduh, op3Ldsb, op3Ldsh})
					decoded.iClass = icLoad;
				else if (ir.f3.op3 inside {op3St, op3Stb, op3Sth})
					decoded.iClass = icStore; // Doubleword and swap fall to illegal
			end
			default:
				decoded.iClass = icIllegal; // CALL not supported
		endcase

		// Privilege is checked here and nowhere else
		if (decoded.iClass inside {icReadState, icWriteState})
		begin
			decoded.stateReg = stateReg_t'(ir.f3.op3[1:0]);
			decoded.privileged = !psrS; // User mode access faults
		end

		decoded.setsCc = (decoded.iClass == icArith) && ir.f3.op3[4];
		decoded.useImm = (ir.f2.op != opFmt2) && ir.f3.i; // Only format 3 has an i bit
	end

endmodule

/* design/trapPriority.sv */
`timescale 1ns/1ps

module trapPriority (
	input logic Clk,
	input logic RESET,
	input logic hardwareTrap,
	input sparcIsaPkg::decodedInstr_t decoded,
	input sparcIsaPkg::instr_u ir,
	input logic cond,
	input logic psrEt,
	input logic decodeStrobe,
	input logic trapTake,
	output logic trapPending,
	output sparcIsaPkg::trapType_t trapType
);
	import sparcIsaPkg::*;

	typedef struct packed {
		logic hw;    // External interrupt
		logic ticc;  // Trap-on-condition taken
		logic fault; // Illegal or privileged instruction
	} trapReq_t;

	trapReq_t pending;
	trapReq_t setReq;
	trapReq_t grant;
	logic [6:0] ticcNum;  // Software trap number
	trapType_t faultType; // Illegal or privileged

	// New requests
	assign setReq.hw = hardwareTrap; // Any cycle
	assign setReq.ticc = decodeStrobe && (decoded.iClass == icTicc) && cond && psrEt;
	assign setReq.fault = decodeStrobe && (decoded.iClass == icIllegal || decoded.privileged);

	// Fixed priority, hardware first
	always_comb
	begin
		grant = '0;
		if (pending.hw)
			grant.hw = 1'b1;
		else if (pending.ticc)
			grant.ticc = 1'b1;
		else
			grant.fault = pending.fault;
	end

	assign trapPending = |pending;
	assign trapType = grant.hw ? ttHardware :
		grant.ticc ? ttTiccBase + {1'b0, ticcNum} : faultType;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			pending <= '0;
		else
			pending <= (trapTake ? pending & ~grant : pending) | setReq; // Clear granted bit only
	end

	// Trap details captured with the request
	always_ff @(posedge Clk)
	begin
		if (setReq.ticc)
			ticcNum <= ir.f3.simm13[6:0];
		if (setReq.fault)
			faultType <= decoded.privileged ? ttPrivileged : ttIllegal;
	end

	// Sequencer only consumes a trap that is pending
	assert property (@(posedge Clk) disable iff (RESET) trapTake |-> trapPending)
		else $error("trapTake with no pending trap");

endmodule

/* design/microSequencer.sv */
`timescale 1ns/1ps

module microSequencer (
	input logic Clk,
	input logic RESET,
	input sparcIsaPkg::instr_u ir,
	input sparcIsaPkg::decodedInstr_t decoded,
	input logic mfc,
	input logic cond,
	input logic trapPending,
	input sparcIsaPkg::trapType_t trapType,
	output logic decodeStrobe,
	output logic trapTake,
	output controlPkg::ctrlWord_t ctrl
);
	import sparcIsaPkg::*;
	import controlPkg::*;

	typedef enum logic [4:0] {
		sInit,
		sFetch,
		sFetchWait,
		sIrLoad,     // IR loads at the end of this cycle
		sDecode,
		sTrapCheck,  // Ticc and faults land here
		sSethi,
		sBranch,
		sArith,
		sMemAddr,
		sStoreData,
		sMemWait,
		sLoadWb,
		sReadState,
		sWriteState,
		sTrap,
		sTrapPc,
		sNpcPlus4,   // NPC <- PC + 4
		sPcFlow
	} seqState_t;

	seqState_t state;
	seqState_t nextState;
	ctrlWord_t ctrlNext;
	logic memDone; // Memory answered an active request

	assign memDone = ctrl.memEnable && mfc;
	assign decodeStrobe = (state == sDecode);
	assign trapTake = (state == sTrap); // Consumes the granted trap

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			state <= sInit;
			ctrl <= '0; // All strobes low in reset and the cycle after
		end
		else
		begin
			state <= nextState;
			ctrl <= ctrlNext;
		end
	end

	always_comb
	begin
		nextState = state;
		ctrlNext = '0;
		// Operand fields straight from the instruction
		ctrlNext.rdAddr = ir.f3.rd;
		ctrlNext.rs1Addr = ir.f3.rs1;
		ctrlNext.rs2Addr = ir.f3.simm13[4:0];
		ctrlNext.aluBSel = decoded.useImm ? bSelExt : bSelRegB;
		ctrlNext.aluOp = aluAdd;
		case (state)
			sInit:
			begin
				ctrlNext.clearAll = 1'b1;
				nextState = sNpcPlus4; // PC is zero after the clear
			end
			sFetch:
			begin
				if (trapPending)
					nextState = sTrap; // Traps win over the next fetch
				else
				begin
					ctrlNext.marLoad = 1'b1; // MAR <- r0 + PC
					ctrlNext.rs1Addr = '0;
					ctrlNext.aluBSel = bSelPc;
					nextState = sFetchWait;
				end
			end
			sFetchWait:
			begin
				ctrlNext.memOp = memFetch;
				if (memDone)
				begin
					ctrlNext.irLoad = 1'b1;
					nextState = sIrLoad;
				end
				else
					ctrlNext.memEnable = 1'b1; // Hold until MFC
			end
			sIrLoad:
				nextState = sDecode;
			sDecode:
			begin
				if (decoded.privileged)
					nextState = sTrapCheck;
				else
					case (decoded.iClass)
						icSethi: nextState = sSethi;
						icBranch: nextState = sBranch;
						icArith: nextState = sArith;
						icLoad: nextState = sMemAddr;
						icStore: nextState = sMemAddr;
						icReadState: nextState = sReadState;
						icWriteState: nextState = sWriteState;
						default: nextState = sTrapCheck; // Ticc or illegal
					endcase
			end
			sTrapCheck:
				nextState = trapPending ? sTrap : sPcFlow; // Untaken Ticc is a nop
			sSethi:
			begin
				ctrlNext.regWrite = 1'b1; // rd <- r0 + imm22 << 10
				ctrlNext.rs1Addr = '0;
				ctrlNext.aluBSel = bSelExt;
				ctrlNext.extSel = extSethi;
				nextState = sPcFlow;
			end
			sBranch:
			begin
				nextState = sPcFlow;
				if (cond)
				begin
					ctrlNext.pcLoad = 1'b1;  // PC <- NPC
					ctrlNext.npcLoad = 1'b1; // NPC <- PC + disp22 << 2
					ctrlNext.aluASel = aSelPc;
					ctrlNext.aluBSel = bSelExt;
					ctrlNext.extSel = extDisp22;
					nextState = sFetch;
				end
			end
			sArith:
			begin
				ctrlNext.regWrite = 1'b1;
				ctrlNext.psrLoad = decoded.setsCc; // icc update
				ctrlNext.aluOp = ir.f3.op3;
				nextState = sPcFlow;
			end
			sMemAddr:
			begin
				ctrlNext.marLoad = 1'b1; // MAR <- rs1 + operand2
				nextState = (decoded.iClass == icLoad) ? sMemWait : sStoreData;
			end
			sStoreData:
			begin
				ctrlNext.mdrLoad = 1'b1; // MDR <- r0 + rd
				ctrlNext.rs1Addr = '0;
				ctrlNext.rs2Addr = ir.f3.rd;
				ctrlNext.aluBSel = bSelRegB;
				nextState = sMemWait;
			end
			sMemWait:
			begin
				ctrlNext.memOp = ir.f3.op3;
				if (memDone && decoded.iClass == icLoad)
				begin
					ctrlNext.mdrLoad = 1'b1;
					ctrlNext.mdrFromMem = 1'b1;
					nextState = sLoadWb;
				end
				else if (memDone)
					nextState = sPcFlow; // Store finished
				else
					ctrlNext.memEnable = 1'b1;
			end
			sLoadWb:
			begin
				ctrlNext.regWrite = 1'b1; // rd <- r0 + MDR
				ctrlNext.rs1Addr = '0;
				ctrlNext.aluBSel = bSelMdr;
				nextState = sPcFlow;
			end
			sReadState:
			begin
				ctrlNext.regWrite = 1'b1;
				ctrlNext.rs1Addr = '0;
				case (decoded.stateReg)
					srPsr: ctrlNext.aluBSel = bSelPsr;
					srWim: ctrlNext.aluBSel = bSelWim;
					srTbr: ctrlNext.aluBSel = bSelTbr;
				endcase
				nextState = sPcFlow;
			end
			sWriteState:
			begin
				ctrlNext.aluOp = aluXor;
				ctrlNext.psrLoad = (decoded.stateReg == srPsr);
				ctrlNext.wimLoad = (decoded.stateReg == srWim);
				ctrlNext.tbrLoad = (decoded.stateReg == srTbr); // TBA from ALU
				nextState = sPcFlow;
			end
			sTrap:
			begin
				ctrlNext.tbrLoad = 1'b1; // tt field only
				ctrlNext.psrTrapEntry = 1'b1;
				ctrlNext.trapType = trapType;
				nextState = sTrapPc;
			end
			sTrapPc:
			begin
				ctrlNext.pcLoad = 1'b1;
				ctrlNext.pcInSel = pcSelTbr;
				nextState = sNpcPlus4;
			end
			sNpcPlus4:
			begin
				ctrlNext.npcLoad = 1'b1;
				ctrlNext.aluASel = aSelPc;
				ctrlNext.aluBSel = bSelFour;
				nextState = sFetch;
			end
			sPcFlow:
			begin
				ctrlNext.pcLoad = 1'b1;  // PC <- NPC
				ctrlNext.npcLoad = 1'b1; // NPC <- NPC + 4
				ctrlNext.aluASel = aSelNpc;
				ctrlNext.aluBSel = bSelFour;
				nextState = sFetch;
			end
			default:
				nextState = sInit;
		endcase
	end

	// IR only captures data memory has delivered
	assert property (@(posedge Clk) disable iff (RESET) ctrl.irLoad |-> $past(memDone))
		else $error("irLoad without MFC");

	// PC comes from NPC or the trap vector, never both PC and NPC from TBR
	assert property (@(posedge Clk) disable iff (RESET) ctrl.pcLoad |->
		(ctrl.pcInSel != pcSelAlu) && !(ctrl.pcInSel == pcSelTbr && ctrl.npcLoad))
		else $error("pcLoad with bad pcInSel");

	// Request held until memory completes
	assert property (@(posedge Clk) disable iff (RESET) $fell(ctrl.memEnable) |-> $past(mfc))
		else $error("memEnable dropped before MFC");

endmodule

/* design/sparcControlUnit.sv */
`timescale 1ns/1ps

module sparcControlUnit (
	input logic Clk,
	input logic RESET,
	input sparcIsaPkg::instr_u ir,
	input logic mfc,
	input logic cond,         // Branch or Ticc condition from the datapath
	input logic psrS,
	input logic psrEt,
	input logic hardwareTrap,
	output controlPkg::ctrlWord_t ctrl
);
	import sparcIsaPkg::*;

	decodedInstr_t decoded;
	logic decodeStrobe;
	logic trapPending;
	logic trapTake;
	trapType_t trapType;

	instrDecoder u_decoder (
		.ir(ir),
		.psrS(psrS),
		.decoded(decoded)
	);

	trapPriority u_trapPriority (
		.Clk(Clk),
		.RESET(RESET),
		.hardwareTrap(hardwareTrap),
		.decoded(decoded),
		.ir(ir),
		.cond(cond),
		.psrEt(psrEt),
		.decodeStrobe(decodeStrobe),
		.trapTake(trapTake),
		.trapPending(trapPending),
		.trapType(trapType)
	);

	microSequencer u_sequencer (
		.Clk(Clk),
		.RESET(RESET),
		.ir(ir),
		.decoded(decoded),
		.mfc(mfc),
		.cond(cond),
		.trapPending(trapPending),
		.trapType(trapType),
		.decodeStrobe(decodeStrobe),
		.trapTake(trapTake),
		.ctrl(ctrl)
	);

endmodule

/* test/controlTests.svh */
// Instruction word builders, field order per format
function automatic instr_u encodeFmt3(input logic [1:0] op, input logic [4:0] rd,
	input logic [5:0] op3, input logic [4:0] rs1, input logic i, input logic [12:0] simm13);
	instr_u w;
	w = {op, rd, op3, rs1, i, simm13};
	return w;
endfunction

function automatic instr_u encodeFmt2(input logic [4:0] rd, input logic [2:0] op2,
	input logic [21:0] imm22);
	instr_u w;
	w = {opFmt2, rd, op2, imm22};
	return w;
endfunction

function automatic logic namedStrobe(input ctrlWord_t c, input string name);
	case (name)
		"regWrite": return c.regWrite;
		"mdrLoad": return c.mdrLoad;
		"marLoad": return c.marLoad;
		"memEnable": return c.memEnable;
		"tbrLoad": return c.tbrLoad;
		"wimLoad": return c.wimLoad;
		"psrLoad": return c.psrLoad;
		default: return 1'b0;
	endcase
endfunction

function automatic int countOf(input string name);
	int n;
	n = 0;
	foreach (trace[k])
		if (namedStrobe(trace[k], name))
			n++;
	return n;
endfunction

function automatic int firstOf(input string name); // -1 when absent
	foreach (trace[k])
		if (namedStrobe(trace[k], name))
			return k;
	return -1;
endfunction

function automatic int lastOf(input string name);
	int idx;
	idx = -1;
	foreach (trace[k])
		if (namedStrobe(trace[k], name))
			idx = k;
	return idx;
endfunction

// PC <- NPC, NPC <- NPC + 4
task automatic expectPcFlow();
	check("pcLoad", trace[$].pcLoad, 1'b1);
	check("npcLoad", trace[$].npcLoad, 1'b1);
	check("pcInSel", trace[$].pcInSel, pcSelNpc);
	check("aluASel", trace[$].aluASel, aSelNpc);
	check("aluBSel", trace[$].aluBSel, bSelFour);
endtask

task automatic expectTrap(input trapType_t tt);
	int t;
	t = firstOf("tbrLoad");
	if (t < 0)
		reportFailure("trap entry did not load TBR");
	else
	begin
		check("trapType", trace[t].trapType, tt);
		check("psrTrapEntry", trace[t].psrTrapEntry, 1'b1);
		check("trap pcLoad", trace[$].pcLoad, 1'b1); // Vector after tbrLoad
		check("trap pcInSel", trace[$].pcInSel, pcSelTbr);
	end
endtask

task automatic verifyMemOps(input logic [5:0] op3);
	foreach (trace[k])
		if (trace[k].memEnable)
			check("memOp", trace[k].memOp, op3);
endtask

task automatic testResetFetch();
	int clears;
	int holds;
	clears = 0;
	holds = 0;
	applyReset();
	nextDelay = 3; // Fetch answered 3 cycles late
	do
	begin
		tick();
		if (ctrl.clearAll)
			clears++;
		if (ctrl.npcLoad)
			check("init aluBSel", ctrl.aluBSel, bSelFour); // NPC <- 4
	end while (!ctrl.memEnable);
	check("clearAll cycles", clears, 1);
	while (!mfc)
	begin
		check("memEnable held", ctrl.memEnable, 1'b1);
		holds++;
		tick();
	end
	check("memEnable hold cycles", holds, 3);
	runInstr(encodeFmt3(opArith, 5'd1, op3Or, 5'd0, 1'b1, 13'd1), 1, 1'b0);
	expectPcFlow();
endtask

task automatic arithCase(input instr_u w);
	int k;
	runInstr(w, 1, 1'b0);
	k = firstOf("regWrite");
	if (k < 0)
		reportFailure("arithmetic instruction wrote no register");
	else
	begin
		check("rdAddr", trace[k].rdAddr, w.f3.rd);
		check("rs1Addr", trace[k].rs1Addr, w.f3.rs1);
		if (!w.f3.i)
			check("rs2Addr", trace[k].rs2Addr, w.f3.simm13[4:0]); // Register form only
		check("aluOp", trace[k].aluOp, w.f3.op3);
		check("aluBSel", trace[k].aluBSel, w.f3.i ? bSelExt : bSelRegB);
	end
	check("psrLoad cycles", countOf("psrLoad"), w.f3.op3[4]); // cc forms only
	expectPcFlow();
endtask

task automatic testArith();
	arithCase(encodeFmt3(opArith, 5'd4, op3Xor, 5'd1, 1'b0, 13'd2));
	arithCase(encodeFmt3(opArith, 5'd9, op3Add | op3CcBit, 5'd3, 1'b1, 13'h1f0));
endtask

task automatic testMemSethi();
	instr_u w;
	int m;
	int d;
	int r;
	int a;
	// Halfword load, memOp differs from the fetch op
	w = encodeFmt3(opMem, 5'd5, op3Lduh, 5'd2, 1'b1, 13'd8);
	runInstr(w, 1, 1'b0);
	m = lastOf("memEnable");
	d = firstOf("mdrLoad");
	r = firstOf("regWrite");
	a = firstOf("marLoad");
	verifyMemOps(w.f3.op3);
	check("load marLoad before memEnable", a >= 0 && a < firstOf("memEnable"), 1'b1);
	if (m < 0 || d < 0 || r < 0)
		reportFailure("load missed its memory access or write back");
	else
	begin
		check("load mdrLoad index", d, m + 1); // Right after the mfc cycle
		check("mdrFromMem", trace[d].mdrFromMem, 1'b1);
		check("load regWrite after mdrLoad", r > d, 1'b1);
		check("load rdAddr", trace[r].rdAddr, w.f3.rd);
	end
	expectPcFlow();

	w = encodeFmt3(opMem, 5'd7, op3St, 5'd2, 1'b0, 13'd3);
	runInstr(w, 1, 1'b0);
	m = firstOf("memEnable");
	d = firstOf("mdrLoad");
	check("store mdrLoad before memEnable", d >= 0 && d < m, 1'b1);
	check("store regWrite cycles", countOf("regWrite"), 0);
	verifyMemOps(w.f3.op3);
	expectPcFlow();

	w = encodeFmt2(5'd3, op2Sethi, 22'h2abcd);
	runInstr(w, 1, 1'b0);
	r = firstOf("regWrite");
	if (r < 0)
		reportFailure("sethi wrote no register");
	else
	begin
		check("sethi rdAddr", trace[r].rdAddr, w.f2.rd);
		check("sethi extSel", trace[r].extSel, extSethi);
	end
	expectPcFlow();
endtask

task automatic testBranch();
	instr_u w;
	w = encodeFmt2(5'b01000, op2Bicc, 22'h3ffff0); // Branch always, backwards
	cond = 1'b1;
	runInstr(w, 1, 1'b0);
	check("taken pcLoad", trace[$].pcLoad, 1'b1);
	check("taken npcLoad", trace[$].npcLoad, 1'b1);
	check("taken pcInSel", trace[$].pcInSel, pcSelNpc);
	check("taken extSel", trace[$].extSel, extDisp22);
	cond = 1'b0;
	runInstr(w, 1, 1'b0);
	expectPcFlow();
	check("untaken extSel not disp22", trace[$].extSel != extDisp22, 1'b1);
endtask

task automatic testStateRegs();
	instr_u w;
	w = encodeFmt3(opArith, 5'd0, op3Wrwim, 5'd1, 1'b1, 13'd5);
	psrS = 1'b1;
	runInstr(w, 1, 1'b0);
	check("wimLoad cycles", countOf("wimLoad"), 1);
	check("tbrLoad cycles", countOf("tbrLoad"), 0);
	expectPcFlow();
	psrS = 1'b0; // Same write from user mode
	runInstr(w, 1, 1'b0);
	check("user wimLoad cycles", countOf("wimLoad"), 0);
	expectTrap(ttPrivileged);
	psrS = 1'b1;
	runInstr(encodeFmt3(opArith, 5'd2, 6'b111111, 5'd0, 1'b0, 13'd0), 1, 1'b0);
	expectTrap(ttIllegal);
endtask

task automatic testTicc();
	instr_u w;
	int t;
	cond = 1'b1;
	psrEt = 1'b1;
	// Bit 7 of simm13 set, only the low 7 bits count
	w = encodeFmt3(opArith, 5'b01000, op3Ticc, 5'd0, 1'b1, 13'h1a5);
	runInstr(w, 1, 1'b0);
	expectTrap(ttTiccBase + 8'h25);

	w = encodeFmt3(opArith, 5'b01000, op3Ticc, 5'd0, 1'b1, 13'h013);
	runInstr(w, 2, 1'b1); // Hardware trap pulse with the Ticc
	if (countOf("tbrLoad") != 2)
		reportFailure("hardware trap and Ticc did not both enter the trap path");
	else
	begin
		t = firstOf("tbrLoad");
		check("first trapType", trace[t].trapType, ttHardware);
		t = lastOf("tbrLoad");
		check("second trapType", trace[t].trapType, ttTiccBase + 8'h13);
	end
	cond = 1'b0;
endtask

/* test/tbControlUnit.sv */
`timescale 1ns/1ps

module tbControlUnit;
	import sparcIsaPkg::*;
	import controlPkg::*;

	localparam int clkPeriod = 40;
	localparam int numTests = 6;
	localparam int cyclesPerTest = 200; // Watchdog budget per test

	logic Clk;
	logic RESET;
	instr_u ir;
	logic mfc;
	logic cond;
	logic psrS;
	logic psrEt;
	logic hardwareTrap;
	ctrlWord_t ctrl;

	int errors;
	int checks;
	int testErrors;      // Error count when the current test began
	int waitLeft;        // Cycles before the memory model answers
	int nextDelay;       // Forced answer delay, -1 for random
	logic busy;          // Memory request in progress
	ctrlWord_t trace[$]; // Control words of the last instruction

	sparcControlUnit u_dut (
		.Clk(Clk),
		.RESET(RESET),
		.ir(ir),
		.mfc(mfc),
		.cond(cond),
		.psrS(psrS),
		.psrEt(psrEt),
		.hardwareTrap(hardwareTrap),
		.ctrl(ctrl)
	);

	always #(clkPeriod / 2) Clk = ~Clk;

	`include "controlTests.svh"

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic reportFailure(input string msg);
		errors++;
		$display("Failure at %0t ns: %s", $time, msg);
	endtask

	// Inputs change 2 ns after the edge, outputs are read at the same point
	task automatic nextCycle();
		@(posedge Clk);
		#2;
	endtask

	// Memory model, answers memEnable with mfc after a delay
	task automatic memCycle();
		if (mfc)
		begin
			mfc = 1'b0; // Answered last cycle
			busy = 1'b0;
			check("memEnable after mfc", ctrl.memEnable, 1'b0);
		end
		else if (busy && !ctrl.memEnable)
		begin
			reportFailure("memEnable dropped before mfc");
			busy = 1'b0;
		end
		else if (ctrl.memEnable)
		begin
			if (!busy)
			begin
				waitLeft = (nextDelay >= 0) ? nextDelay : $urandom_range(5, 0);
				nextDelay = -1;
				busy = 1'b1;
			end
			if (waitLeft == 0)
				mfc = 1'b1;
			else
				waitLeft--;
		end
	endtask

	task automatic tick();
		nextCycle();
		memCycle();
	endtask

	// Control strobes in one vector
	function automatic logic [12:0] strobeBits(input ctrlWord_t c);
		return {c.pcLoad, c.npcLoad, c.irLoad, c.marLoad, c.mdrLoad, c.regWrite, c.psrLoad,
			c.wimLoad, c.tbrLoad, c.clearAll, c.psrTrapEntry, c.memEnable, c.mdrFromMem};
	endfunction

	task automatic applyReset();
		RESET = 1'b1;
		repeat (8)
		begin
			nextCycle();
			check("strobes in reset", strobeBits(ctrl), '0);
		end
		RESET = 1'b0;
	endtask

	// Serve one fetch, load instr into ir, trace until the given number of end markers
	task automatic runInstr(input instr_u instr, input int markers, input logic hwPulse);
		int seen;
		seen = 0;
		trace.delete();
		while (!mfc)
			tick(); // Wait for the fetch answer
		tick();
		check("irLoad after mfc", ctrl.irLoad, 1'b1);
		ir = instr;
		hardwareTrap = hwPulse; // One cycle only
		while (seen < markers)
		begin
			tick();
			hardwareTrap = 1'b0;
			trace.push_back(ctrl);
			if (ctrl.irLoad)
				reportFailure("second irLoad before the instruction ended");
			if (ctrl.pcLoad && (ctrl.npcLoad || ctrl.pcInSel == pcSelTbr))
				seen++; // PC flow, taken branch or trap vector
		end
	endtask

	task automatic beginTest();
		testErrors = errors;
	endtask

	task automatic reportTest(input string name);
		if (errors == testErrors)
			$display("%s: passed", name);
		else
			$display("%s: %0d errors", name, errors - testErrors);
	endtask

	initial
	begin
		#(numTests * cyclesPerTest * clkPeriod);
		$display("Timeout after %0d cycles, the DUT stopped responding",
			numTests * cyclesPerTest);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		Clk = 1'b0;
		RESET = 1'b1;
		ir = '0;
		mfc = 1'b0;
		cond = 1'b0;
		psrS = 1'b1; // Supervisor
		psrEt = 1'b1;
		hardwareTrap = 1'b0;
		errors = 0;
		checks = 0;
		testErrors = 0;
		waitLeft = 0;
		nextDelay = -1;
		busy = 1'b0;
		void'($urandom(80526));

		beginTest();
		testResetFetch();
		reportTest("reset and fetch");
		beginTest();
		testArith();
		reportTest("arithmetic");
		beginTest();
		testMemSethi();
		reportTest("memory and sethi");
		beginTest();
		testBranch();
		reportTest("branches");
		beginTest();
		testStateRegs();
		reportTest("state registers and faults");
		beginTest();
		testTicc();
		reportTest("ticc and priority");

		$display("Tests: %0d, checks: %0d, errors: %0d", numTests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* sources.f */
+incdir+test
design/sparcIsaPkg.sv
design/controlPkg.sv
design/instrDecoder.sv
design/trapPriority.sv
design/microSequencer.sv
design/sparcControlUnit.sv
test/tbControlUnit.sv

/* run.sh */
#!/bin/sh
# Build the control unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbControlUnit \
	-f sources.f -o simControlUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simControlUnit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1
